//--- hdl/board_pkg.sv
`default_nettype none

package board_pkg;

	// ****************************************
	// timing
	// ****************************************
	localparam logic [31:0] tick_div = 32'd50_000_000;

	// ****************************************
	// counters and display
	// ****************************************
	localparam int up_width   = 8;
	localparam int down_width = 3;
	localparam logic [up_width-1:0] count_mod = 100;
	localparam int num_digits = 8;
	localparam int seg_w      = 8;

	// active low, bit 7 is the decimal point
	localparam logic [seg_w-1:0] seg_patterns [0:9] = '{
		8'hc0, 8'hf9, 8'ha4, 8'hb0, 8'h99,
		8'h92, 8'h82, 8'hf8, 8'h80, 8'h90
	};
	localparam logic [seg_w-1:0] seg_blank = '1;

	// equal samples for a detect
	localparam int run_len = 4;

endpackage

`default_nettype wire

//--- hdl/alu_pkg.sv
`default_nettype none

package alu_pkg;

	// ****************************************
	// alu opcodes
	// ****************************************
	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_not,
		op_and,
		op_or,
		op_xor,
		op_lt,
		op_eq
	} alu_op_e;

	// ****************************************
	// shifter modes
	// ****************************************
	typedef enum logic {
		shift_left,
		shift_right
	} shift_dir_e;

	typedef enum logic {
		shift_logical,
		shift_arith
	} shift_kind_e;

endpackage

`default_nettype wire

//--- hdl/tick_timer.sv
`default_nettype none

module tick_timer #(
	parameter logic [31:0] div = board_pkg::tick_div
) (
	input  wire  clk,
	input  wire  reset,
	output logic tick
);

	logic [31:0] count;

	// last cycle of each period
	assign tick = (count == div - 32'd1);

	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
		end else if (tick) begin
			count <= '0;
		end else begin
			count <= count + 32'd1;
		end
	end

	// tick is a single-cycle pulse
	tick_single: assert property (
		@(posedge clk) disable iff (reset)
		tick |=> !tick
	);

endmodule

`default_nettype wire

//--- hdl/tick_counters.sv
`default_nettype none

module tick_counters (
	input  wire                                clk,
	input  wire                                reset,
	input  wire                                tick,
	input  wire                                en,
	output logic [board_pkg::up_width-1:0]   up_count,
	output logic [board_pkg::down_width-1:0] down_count
);

	logic step;

	assign step = tick && en;

	// decimal wrap at count_mod
	always_ff @(posedge clk) begin
		if (reset) begin
			up_count <= '0;
		end else if (step) begin
			if (up_count == board_pkg::count_mod - 1'b1) begin
				up_count <= '0;
			end else begin
				up_count <= up_count + 1'b1;
			end
		end
	end

	// plain binary wrap
	always_ff @(posedge clk) begin
		if (reset) begin
			down_count <= '0;
		end else if (step) begin
			down_count <= down_count - 1'b1;
		end
	end

	up_in_range: assert property (
		@(posedge clk) disable iff (reset)
		up_count < board_pkg::count_mod
	);

endmodule

`default_nettype wire

//--- hdl/seq_detector.sv
`default_nettype none

module seq_detector (
	input  wire  clk,
	input  wire  reset,
	input  wire  clr,
	input  wire  tick,
	input  wire  din,
	output logic dout
);

	typedef enum logic [2:0] {
		st_idle,
		st_zero1,
		st_zero2,
		st_zero3,
		st_one1,
		st_one2,
		st_one3
	} state_e;

	localparam logic [2:0] run_max = 3'(board_pkg::run_len);

	state_e     state;
	state_e     state_next;
	logic       cur_bit;
	logic [2:0] cur_len;
	logic [2:0] run_next;
	logic [2:0] len_keep;
	logic       same;
	logic       hit;

	// decode the run held in the state
	always_comb begin
		cur_bit = 1'b0;
		cur_len = 3'd0;
		case (state)
			st_zero1: cur_len = 3'd1;
			st_zero2: cur_len = 3'd2;
			st_zero3: cur_len = 3'd3;
			st_one1: begin
				cur_bit = 1'b1;
				cur_len = 3'd1;
			end
			st_one2: begin
				cur_bit = 1'b1;
				cur_len = 3'd2;
			end
			st_one3: begin
				cur_bit = 1'b1;
				cur_len = 3'd3;
			end
			default: ;
		endcase
	end

	assign same     = (state != st_idle) && (din == cur_bit);
	assign run_next = same ? cur_len + 3'd1 : 3'd1;
	assign hit      = (run_next >= run_max);
	// saturate once the run is long enough
	assign len_keep = hit ? run_max - 3'd1 : run_next;

	always_comb begin
		case (len_keep)
			3'd1: state_next = din ? st_one1 : st_zero1;
			3'd2: state_next = din ? st_one2 : st_zero2;
			3'd3: state_next = din ? st_one3 : st_zero3;
			default: state_next = st_idle;
		endcase
	end

	// clear wins over a sample
	always_ff @(posedge clk) begin
		if (reset || clr) begin
			state <= st_idle;
			dout  <= 1'b0;
		end else if (tick) begin
			state <= state_next;
			dout  <= hit;
		end
	end

endmodule

`default_nettype wire

//--- hdl/seg_display.sv
`default_nettype none

module seg_display (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire  [board_pkg::up_width-1:0]   up_count,
	input  wire  [board_pkg::down_width-1:0] down_count,
	output logic [board_pkg::seg_w-1:0]      seg0,
	output logic [board_pkg::seg_w-1:0]      seg1,
	output logic [board_pkg::seg_w-1:0]      seg2,
	output logic [board_pkg::seg_w-1:0]      seg3,
	output logic [board_pkg::seg_w-1:0]      seg4,
	output logic [board_pkg::seg_w-1:0]      seg5,
	output logic [board_pkg::seg_w-1:0]      seg6,
	output logic [board_pkg::seg_w-1:0]      seg7
);

	logic [board_pkg::seg_w-1:0] digit_q [board_pkg::num_digits];
	logic [3:0] ones;
	logic [3:0] tens;

	// up count never exceeds 99
	assign ones = 4'(up_count % 8'd10);
	assign tens = 4'(up_count / 8'd10);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < board_pkg::num_digits; i++) begin
				digit_q[i] <= board_pkg::seg_blank;
			end
			digit_q[0] <= board_pkg::seg_patterns[0];
			digit_q[1] <= board_pkg::seg_patterns[0];
			digit_q[2] <= board_pkg::seg_patterns[0];
		end else begin
			digit_q[0] <= board_pkg::seg_patterns[ones];
			digit_q[1] <= board_pkg::seg_patterns[tens];
			digit_q[2] <= board_pkg::seg_patterns[down_count];
			// unused digits stay dark
			for (int i = 3; i < board_pkg::num_digits; i++) begin
				digit_q[i] <= board_pkg::seg_blank;
			end
		end
	end

	assign seg0 = digit_q[0];
	assign seg1 = digit_q[1];
	assign seg2 = digit_q[2];
	assign seg3 = digit_q[3];
	assign seg4 = digit_q[4];
	assign seg5 = digit_q[5];
	assign seg6 = digit_q[6];
	assign seg7 = digit_q[7];

endmodule

`default_nettype wire

//--- hdl/alu_4bit.sv
`default_nettype none

module alu_4bit (
	input  alu_pkg::alu_op_e op,
	input  wire  [3:0]       a,
	input  wire  [3:0]       b,
	output logic [3:0]       res,
	output logic             zero,
	output logic             carry,
	output logic             overflow
);

	logic [4:0] sum;
	logic [4:0] diff;

	// subtract as a + ~b + 1
	assign sum  = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} + {1'b0, ~b} + 5'd1;

	always_comb begin
		res      = 4'd0;
		carry    = 1'b0;
		overflow = 1'b0;
		case (op)
			alu_pkg::op_add: begin
				res      = sum[3:0];
				carry    = sum[4];
				overflow = (a[3] == b[3]) && (sum[3] != a[3]);
			end
			alu_pkg::op_sub: begin
				res      = diff[3:0];
				carry    = diff[4];
				overflow = (a[3] != b[3]) && (diff[3] != a[3]);
			end
			alu_pkg::op_not: res = ~a;
			alu_pkg::op_and: res = a & b;
			alu_pkg::op_or:  res = a | b;
			alu_pkg::op_xor: res = a ^ b;
			// signed compare
			alu_pkg::op_lt:  res = {3'd0, $signed(a) < $signed(b)};
			alu_pkg::op_eq:  res = {3'd0, a == b};
			default: res = 4'd0;
		endcase
	end

	assign zero = (res == 4'd0);

endmodule

`default_nettype wire

//--- hdl/barrel_shifter.sv
`default_nettype none

module barrel_shifter (
	input  wire  [31:0]          data,
	input  wire  [4:0]           shamt,
	input  alu_pkg::shift_dir_e  dir,
	input  alu_pkg::shift_kind_e kind,
	output logic [31:0]          q
);

	logic        fill;
	logic [31:0] stage [6];

	// sign fill only for right arithmetic
	assign fill = (dir == alu_pkg::shift_right) && (kind == alu_pkg::shift_arith) && data[31];

	assign stage[0] = data;

	for (genvar k = 0; k < 5; k++) begin : g_stage
		localparam int n = 1 << k;
		logic [31:0] shifted;

		assign shifted = (dir == alu_pkg::shift_left) ?
			{stage[k][31-n:0], {n{1'b0}}} :
			{{n{fill}}, stage[k][31:n]};
		assign stage[k+1] = shamt[k] ? shifted : stage[k];
	end

	assign q = stage[5];

endmodule

`default_nettype wire

//--- hdl/board_top.sv
`default_nettype none

module board_top #(
	parameter logic [31:0] div = board_pkg::tick_div
) (
	input  wire                                 clk,
	input  wire                                 reset,
	input  wire                                 counter_en,
	input  wire                                 rand_in,
	input  wire                                 sm_clr,
	input  alu_pkg::alu_op_e                    alu_op,
	input  wire  [3:0]                          alu_a,
	input  wire  [3:0]                          alu_b,
	input  wire  [31:0]                         sft_data,
	input  wire  [4:0]                          sft_shamt,
	input  alu_pkg::shift_dir_e                 sft_dir,
	input  alu_pkg::shift_kind_e                sft_kind,
	output logic [board_pkg::up_width-1:0]   inc_counter_out,
	output logic [board_pkg::down_width-1:0] dec_counter_out,
	output logic                                sm_out,
	output logic [3:0]                          alu_res,
	output logic                                alu_zero,
	output logic                                alu_carry,
	output logic                                alu_overflow,
	output logic [31:0]                         sft_q,
	output logic [board_pkg::seg_w-1:0]      seg0,
	output logic [board_pkg::seg_w-1:0]      seg1,
	output logic [board_pkg::seg_w-1:0]      seg2,
	output logic [board_pkg::seg_w-1:0]      seg3,
	output logic [board_pkg::seg_w-1:0]      seg4,
	output logic [board_pkg::seg_w-1:0]      seg5,
	output logic [board_pkg::seg_w-1:0]      seg6,
	output logic [board_pkg::seg_w-1:0]      seg7
);

	logic tick;

	// ****************************************
	// tick driven blocks
	// ****************************************
	tick_timer #(.div(div)) u_tick_timer (
		.clk  (clk),
		.reset(reset),
		.tick (tick)
	);

	tick_counters u_tick_counters (
		.clk       (clk),
		.reset     (reset),
		.tick      (tick),
		.en        (counter_en),
		.up_count  (inc_counter_out),
		.down_count(dec_counter_out)
	);

	seq_detector u_seq_detector (
		.clk  (clk),
		.reset(reset),
		.clr  (sm_clr),
		.tick (tick),
		.din  (rand_in),
		.dout (sm_out)
	);

	seg_display u_seg_display (
		.clk       (clk),
		.reset     (reset),
		.up_count  (inc_counter_out),
		.down_count(dec_counter_out),
		.seg0      (seg0),
		.seg1      (seg1),
		.seg2      (seg2),
		.seg3      (seg3),
		.seg4      (seg4),
		.seg5      (seg5),
		.seg6      (seg6),
		.seg7      (seg7)
	);

	// ****************************************
	// datapath
	// ****************************************
	alu_4bit u_alu_4bit (
		.op      (alu_op),
		.a       (alu_a),
		.b       (alu_b),
		.res     (alu_res),
		.zero    (alu_zero),
		.carry   (alu_carry),
		.overflow(alu_overflow)
	);

	barrel_shifter u_barrel_shifter (
		.data (sft_data),
		.shamt(sft_shamt),
		.dir  (sft_dir),
		.kind (sft_kind),
		.q    (sft_q)
	);

endmodule

`default_nettype wire

//--- dv/tb_board_top.sv
`default_nettype none

module tb_board_top;

	timeunit 1ns;
	timeprecision 1ps;

	localparam logic [31:0] div = 32'd5;
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;
	localparam int tick_goal = 300;
	localparam int check_goal = 2000;
	localparam int cycle_limit = 4000;

	logic clk;
	logic reset;
	logic counter_en;
	logic rand_in;
	logic sm_clr;
	alu_pkg::alu_op_e alu_op;
	logic [3:0] alu_a;
	logic [3:0] alu_b;
	logic [31:0] sft_data;
	logic [4:0] sft_shamt;
	alu_pkg::shift_dir_e sft_dir;
	alu_pkg::shift_kind_e sft_kind;
	logic [board_pkg::up_width-1:0] inc_counter_out;
	logic [board_pkg::down_width-1:0] dec_counter_out;
	logic sm_out;
	logic [3:0] alu_res;
	logic alu_zero;
	logic alu_carry;
	logic alu_overflow;
	logic [31:0] sft_q;
	logic [board_pkg::seg_w-1:0] seg_out [board_pkg::num_digits];

	logic [31:0] lfsr;
	// model state
	logic [31:0] m_div_cnt;
	logic [board_pkg::up_width-1:0] m_up;
	logic [board_pkg::down_width-1:0] m_down;
	logic m_bit;
	int m_len;
	logic m_dout;
	logic [board_pkg::seg_w-1:0] m_seg [board_pkg::num_digits];
	int n_ticks;
	int n_checks;
	int cycles;

	board_top #(.div(div)) u_board_top (
		.clk            (clk),
		.reset          (reset),
		.counter_en     (counter_en),
		.rand_in        (rand_in),
		.sm_clr         (sm_clr),
		.alu_op         (alu_op),
		.alu_a          (alu_a),
		.alu_b          (alu_b),
		.sft_data       (sft_data),
		.sft_shamt      (sft_shamt),
		.sft_dir        (sft_dir),
		.sft_kind       (sft_kind),
		.inc_counter_out(inc_counter_out),
		.dec_counter_out(dec_counter_out),
		.sm_out         (sm_out),
		.alu_res        (alu_res),
		.alu_zero       (alu_zero),
		.alu_carry      (alu_carry),
		.alu_overflow   (alu_overflow),
		.sft_q          (sft_q),
		.seg0           (seg_out[0]),
		.seg1           (seg_out[1]),
		.seg2           (seg_out[2]),
		.seg3           (seg_out[3]),
		.seg4           (seg_out[4]),
		.seg5           (seg_out[5]),
		.seg6           (seg_out[6]),
		.seg7           (seg_out[7])
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] val;
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
		end
		return val;
	endfunction

	// ****************************************
	// reference models
	// ****************************************
	// packed as {res, zero, carry, overflow}
	function automatic logic [6:0] alu_expect(input alu_pkg::alu_op_e op,
			input logic [3:0] a, input logic [3:0] b);
		int sa;
		int sb;
		int wide;
		logic [3:0] res;
		logic carry;
		logic ovf;
		sa = a[3] ? int'(a) - 16 : int'(a);
		sb = b[3] ? int'(b) - 16 : int'(b);
		res = 4'd0;
		carry = 1'b0;
		ovf = 1'b0;
		case (op)
			alu_pkg::op_add: begin
				wide = int'(a) + int'(b);
				res = wide[3:0];
				carry = wide > 15;
				ovf = (sa + sb > 7) || (sa + sb < -8);
			end
			alu_pkg::op_sub: begin
				wide = int'(a) - int'(b);
				res = wide[3:0];
				// carry set when no borrow
				carry = a >= b;
				ovf = (sa - sb > 7) || (sa - sb < -8);
			end
			alu_pkg::op_not: res = ~a;
			alu_pkg::op_and: res = a & b;
			alu_pkg::op_or: res = a | b;
			alu_pkg::op_xor: res = a ^ b;
			alu_pkg::op_lt: res = (sa < sb) ? 4'd1 : 4'd0;
			alu_pkg::op_eq: res = (a == b) ? 4'd1 : 4'd0;
			default: res = 4'd0;
		endcase
		return {res, res == 4'd0, carry, ovf};
	endfunction

	function automatic logic [31:0] shift_expect(input logic [31:0] data,
			input logic [4:0] shamt, input alu_pkg::shift_dir_e dir,
			input alu_pkg::shift_kind_e kind);
		logic [31:0] val;
		if (dir == alu_pkg::shift_left) begin
			val = data << shamt;
		end else if (kind == alu_pkg::shift_arith) begin
			val = $unsigned($signed(data) >>> shamt);
		end else begin
			val = data >> shamt;
		end
		return val;
	endfunction

	// next clock edge as the DUT sees it
	task automatic advance_model();
		logic tick;
		int len;
		tick = (m_div_cnt == div - 32'd1);
		m_seg[0] = board_pkg::seg_patterns[4'(m_up % 8'd10)];
		m_seg[1] = board_pkg::seg_patterns[4'(m_up / 8'd10)];
		m_seg[2] = board_pkg::seg_patterns[4'(m_down)];
		for (int i = 3; i < board_pkg::num_digits; i++) begin
			m_seg[i] = board_pkg::seg_blank;
		end
		if (tick && counter_en) begin
			m_up = (m_up == board_pkg::count_mod - 8'd1) ? 8'd0 : m_up + 8'd1;
			m_down = m_down - 3'd1;
		end
		if (sm_clr) begin
			m_len = 0;
			m_dout = 1'b0;
		end else if (tick) begin
			if (m_len != 0 && rand_in == m_bit) begin
				len = (m_len < board_pkg::run_len) ? m_len + 1 : m_len;
			end else begin
				len = 1;
			end
			m_bit = rand_in;
			m_len = len;
			m_dout = (len >= board_pkg::run_len);
		end
		if (tick) begin
			n_ticks++;
		end
		m_div_cnt = tick ? 32'd0 : m_div_cnt + 32'd1;
	endtask

	task automatic drive_inputs();
		logic [31:0] r;
		r = random_bits(2);
		counter_en <= |r[1:0];
		r = random_bits(1);
		rand_in <= r[0];
		r = random_bits(6);
		sm_clr <= (r[5:0] == 6'd0);
		r = random_bits(3);
		alu_op <= alu_pkg::alu_op_e'(r[2:0]);
		r = random_bits(4);
		alu_a <= r[3:0];
		r = random_bits(4);
		alu_b <= r[3:0];
		sft_data <= random_bits(32);
		r = random_bits(5);
		sft_shamt <= r[4:0];
		r = random_bits(1);
		sft_dir <= alu_pkg::shift_dir_e'(r[0]);
		r = random_bits(1);
		sft_kind <= alu_pkg::shift_kind_e'(r[0]);
	endtask

	// ****************************************
	// compare tasks
	// ****************************************
	task automatic report_error(input string msg);
		$display("error at %0d ns: %s", $time, msg);
		$display("Something failed");
		$fatal(1, "stopped at first mismatch");
	endtask

	task automatic check_count(input logic [board_pkg::up_width-1:0] got_up,
			input logic [board_pkg::up_width-1:0] exp_up,
			input logic [board_pkg::down_width-1:0] got_down,
			input logic [board_pkg::down_width-1:0] exp_down);
		if (got_up !== exp_up || got_down !== exp_down) begin
			report_error($sformatf("counts up %0d down %0d, expected up %0d down %0d",
				got_up, got_down, exp_up, exp_down));
		end
	endtask

	task automatic check_seg(input int idx, input logic [board_pkg::seg_w-1:0] got,
			input logic [board_pkg::seg_w-1:0] exp);
		if (got !== exp) begin
			report_error($sformatf("seg%0d is %h, expected %h", idx, got, exp));
		end
	endtask

	task automatic check_detect(input logic got, input logic exp);
		if (got !== exp) begin
			report_error($sformatf("sm_out is %b, expected %b", got, exp));
		end
	endtask

	task automatic check_alu(input alu_pkg::alu_op_e op, input logic [3:0] a,
			input logic [3:0] b, input logic [6:0] got, input logic [6:0] exp);
		if (got !== exp) begin
			report_error($sformatf("alu %s a=%h b=%h got %h/%b/%b/%b, expected %h/%b/%b/%b",
				op.name(), a, b, got[6:3], got[2], got[1], got[0],
				exp[6:3], exp[2], exp[1], exp[0]));
		end
	endtask

	task automatic check_shift(input logic [31:0] data, input logic [4:0] shamt,
			input alu_pkg::shift_dir_e dir, input alu_pkg::shift_kind_e kind,
			input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			report_error($sformatf("shift %s %s of %h by %0d gave %h, expected %h",
				dir.name(), kind.name(), data, shamt, got, exp));
		end
	endtask

	// ****************************************
	// main sequence
	// ****************************************
	initial begin
		lfsr = 32'h6bbd_049b;
		reset = 1'b1;
		counter_en = 1'b0;
		rand_in = 1'b0;
		sm_clr = 1'b0;
		alu_op = alu_pkg::op_add;
		alu_a = 4'd0;
		alu_b = 4'd0;
		sft_data = 32'd0;
		sft_shamt = 5'd0;
		sft_dir = alu_pkg::shift_left;
		sft_kind = alu_pkg::shift_logical;
		m_div_cnt = 32'd0;
		m_up = '0;
		m_down = '0;
		m_bit = 1'b0;
		m_len = 0;
		m_dout = 1'b0;
		n_ticks = 0;
		n_checks = 0;
		cycles = 0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		drive_inputs();
		@(negedge clk);

		// state right after reset
		check_count(inc_counter_out, 8'd0, dec_counter_out, 3'd0);
		check_detect(sm_out, 1'b0);
		for (int i = 0; i < board_pkg::num_digits; i++) begin
			m_seg[i] = (i < 3) ? board_pkg::seg_patterns[0] : board_pkg::seg_blank;
			check_seg(i, seg_out[i], m_seg[i]);
		end

		while (n_ticks < tick_goal || n_checks < check_goal) begin
			if (cycles >= cycle_limit) begin
				$display("timed out before reaching the tick and check counts");
				$display("Something failed");
				$fatal(1, "timeout");
			end
			check_count(inc_counter_out, m_up, dec_counter_out, m_down);
			for (int i = 0; i < board_pkg::num_digits; i++) begin
				check_seg(i, seg_out[i], m_seg[i]);
			end
			check_detect(sm_out, m_dout);
			check_alu(alu_op, alu_a, alu_b, {alu_res, alu_zero, alu_carry, alu_overflow},
				alu_expect(alu_op, alu_a, alu_b));
			check_shift(sft_data, sft_shamt, sft_dir, sft_kind, sft_q,
				shift_expect(sft_data, sft_shamt, sft_dir, sft_kind));
			n_checks++;
			advance_model();
			@(posedge clk);
			drive_inputs();
			@(negedge clk);
			cycles++;
		end

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

//--- src.f
hdl/board_pkg.sv
hdl/alu_pkg.sv
hdl/tick_timer.sv
hdl/tick_counters.sv
hdl/seq_detector.sv
hdl/seg_display.sv
hdl/alu_4bit.sv
hdl/barrel_shifter.sv
hdl/board_top.sv
dv/tb_board_top.sv

//--- Makefile
OBJ_DIR := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f src.f --top-module tb_board_top -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/Vtb_board_top

clean:
	rm -rf $(OBJ_DIR)
